//--- src/io_pkg.sv
`default_nettype none

package io_pkg;

  // bus widths, fixed by the address map below
  localparam int addr_width = 10;
  localparam int data_width = 16;

  localparam logic [addr_width-1:0] addr_led_lcd = 10'h080;
  localparam logic [addr_width-1:0] addr_lcd     = 10'h081;
  localparam logic [addr_width-1:0] addr_gpio    = 10'h082;

  typedef struct packed {
    logic                  wen;
    logic                  byt;   // byte access, low byte only
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } req_t;

  typedef struct packed {
    logic [data_width-1:0] rdata;
  } rsp_t;

  // register select, produced by decode
  typedef enum logic [1:0] {
    sel_none    = 2'd0,
    sel_led_lcd = 2'd1,
    sel_lcd_hi  = 2'd2,
    sel_gpio    = 2'd3
  } sel_t;

endpackage

`default_nettype wire

//--- src/io_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module io_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire                          sys_clk,
  input  wire                          rst_n,
  input  wire                          push,
  input  wire payload_t                push_data,
  input  wire                          pop,
  output payload_t                     pop_data,
  output logic                         not_empty,
  output logic [$clog2(DEPTH+1)-1:0]   free
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH+1);

  payload_t         mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  always_ff @(posedge sys_clk) begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_w'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == ptr_w'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push+pop
      endcase
    end
  end

  assign pop_data  = mem[rd_ptr];  // head visible the cycle after write
  assign not_empty = (count != '0);
  assign free      = cnt_w'(DEPTH) - count;

  // ************************************************************************
  // protocol checks
  // ************************************************************************

  // a push into a full queue is fine when the head leaves at the same edge
  a_no_push_full: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (push && !pop) |-> (count != cnt_w'(DEPTH))
  ) else $error("io_fifo: push while full");

  a_no_pop_empty: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    pop |-> not_empty
  ) else $error("io_fifo: pop while empty");

endmodule

`default_nettype wire

//--- src/io_decode.sv
`timescale 1ns/1ps
`default_nettype none

module io_decode #(
  parameter int RSP_DEPTH = 4
) (
  input  wire                                sys_clk,
  input  wire                                rst_n,
  input  wire                                req_not_empty,
  input  wire io_pkg::req_t                  req_data,
  output logic                               req_pop,
  input  wire [$clog2(RSP_DEPTH+1)-1:0]      rsp_free,
  output logic                               op_valid,
  output logic                               op_wen,
  output logic                               op_byt,
  output io_pkg::sel_t                       op_sel,
  output logic [io_pkg::data_width-1:0]      op_wdata
);

  localparam int aw = io_pkg::addr_width;

  logic         rd_in_op;    // read sitting in this stage
  logic         rd_in_regs;  // read sitting in the register stage
  logic [1:0]   rd_inflight;
  io_pkg::sel_t sel_next;

  assign rd_in_op    = op_valid && !op_wen;
  assign rd_inflight = {1'b0, rd_in_op} + {1'b0, rd_in_regs};

  // reads only go when a response slot is guaranteed
  assign req_pop = req_not_empty &&
                   (req_data.wen || (32'(rsp_free) > 32'(rd_inflight)));

  always_comb begin
    sel_next = io_pkg::sel_none;
    if (req_data.wen) begin
      case (req_data.addr)  // exact match for writes
        io_pkg::addr_led_lcd: sel_next = io_pkg::sel_led_lcd;
        io_pkg::addr_lcd:     sel_next = io_pkg::sel_lcd_hi;
        io_pkg::addr_gpio:    sel_next = io_pkg::sel_gpio;
        default:              sel_next = io_pkg::sel_none;
      endcase
    end else if (req_data.addr[aw-1:1] == io_pkg::addr_led_lcd[aw-1:1]) begin
      sel_next = io_pkg::sel_led_lcd;  // 0x080 / 0x081
    end else if (req_data.addr[aw-1:1] == io_pkg::addr_gpio[aw-1:1]) begin
      sel_next = io_pkg::sel_gpio;     // 0x082 / 0x083
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid   <= 1'b0;
      op_wen     <= 1'b0;
      op_byt     <= 1'b0;
      op_sel     <= io_pkg::sel_none;
      rd_in_regs <= 1'b0;
    end else begin
      op_valid   <= req_pop;
      op_wen     <= req_data.wen;
      op_byt     <= req_data.byt;
      op_sel     <= sel_next;
      rd_in_regs <= rd_in_op;
    end
  end

  always_ff @(posedge sys_clk) begin
    op_wdata <= req_data.wdata;
  end

endmodule

`default_nettype wire

//--- src/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  wire                             sys_clk,
  input  wire                             rst_n,
  input  wire                             op_valid,
  input  wire                             op_wen,
  input  wire                             op_byt,
  input  wire io_pkg::sel_t               op_sel,
  input  wire [io_pkg::data_width-1:0]    op_wdata,
  output logic                            rd_push,
  output logic [io_pkg::data_width-1:0]   rd_data,
  output logic [5:0]                      led,
  output logic                            lcd_e,
  output logic                            lcd_rw,
  output logic                            lcd_rs,
  output logic [3:0]                      lcd_db,
  output logic [7:0]                      gpio
);

  logic [7:0]                    led_q;
  logic [7:0]                    lcd_q;
  logic [7:0]                    gpio_q;
  logic [io_pkg::data_width-1:0] rd_next;
  logic                          wr_en;

  assign wr_en = op_valid && op_wen;

  // ************************************************************************
  // register writes
  // ************************************************************************

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q  <= 8'd0;
      lcd_q  <= 8'd0;
      gpio_q <= 8'd0;
    end else if (wr_en) begin
      case (op_sel)
        io_pkg::sel_led_lcd: begin
          if (op_byt)
            led_q <= op_wdata[7:0];
          else
            {lcd_q, led_q} <= op_wdata;
        end
        io_pkg::sel_lcd_hi: lcd_q  <= op_wdata[15:8];  // high byte lane
        io_pkg::sel_gpio:   gpio_q <= op_wdata[7:0];
        default:            ;
      endcase
    end
  end

  // ************************************************************************
  // read path
  // ************************************************************************

  always_comb begin
    case (op_sel)
      io_pkg::sel_led_lcd: rd_next = {lcd_q, led_q};
      io_pkg::sel_gpio:    rd_next = {8'd0, gpio_q};
      default:             rd_next = '0;  // unmapped
    endcase
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      rd_push <= 1'b0;
    else
      rd_push <= op_valid && !op_wen;
  end

  always_ff @(posedge sys_clk) begin
    rd_data <= rd_next;
  end

  // pin mapping
  assign led    = led_q[5:0];
  assign lcd_e  = lcd_q[0];
  assign lcd_rw = lcd_q[1];
  assign lcd_rs = lcd_q[2];
  assign lcd_db = lcd_q[7:4];
  assign gpio   = gpio_q;

  // decode never hands a read the lcd high-byte select
  a_sel_legal: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    op_valid |-> (!$isunknown(op_sel) && (op_wen || op_sel != io_pkg::sel_lcd_hi))
  ) else $error("io_regs: illegal op_sel");

endmodule

`default_nettype wire

//--- src/io_rsp_port.sv
`timescale 1ns/1ps
`default_nettype none

module io_rsp_port #(
  parameter int DEPTH = 4
) (
  input  wire                             sys_clk,
  input  wire                             rst_n,
  input  wire                             rd_push,
  input  wire [io_pkg::data_width-1:0]    rd_data,
  output logic [$clog2(DEPTH+1)-1:0]      rsp_free,
  input  wire                             rsp_credit,
  output logic                            rsp_valid,
  output logic [io_pkg::data_width-1:0]   rsp_rdata
);

  localparam logic [7:0] credit_max = 8'd255;

  io_pkg::rsp_t push_word;
  io_pkg::rsp_t head_word;
  logic         fifo_pop;
  logic         fifo_not_empty;
  logic [7:0]   credits;   // granted by host, not yet spent

  assign push_word.rdata = rd_data;

  io_fifo #(
    .payload_t (io_pkg::rsp_t),
    .DEPTH     (DEPTH)
  ) u_rsp_fifo (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .push      (rd_push),
    .push_data (push_word),
    .pop       (fifo_pop),
    .pop_data  (head_word),
    .not_empty (fifo_not_empty),
    .free      (rsp_free)
  );

  assign fifo_pop = fifo_not_empty && (credits != 8'd0);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      credits   <= 8'd0;
      rsp_valid <= 1'b0;
    end else begin
      case ({rsp_credit, fifo_pop})
        2'b10:   credits <= credits + 8'd1;
        2'b01:   credits <= credits - 8'd1;
        default: credits <= credits;
      endcase
      rsp_valid <= fifo_pop;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (fifo_pop)
      rsp_rdata <= head_word.rdata;
  end

  a_credit_ceiling: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (credits == credit_max) |-> !(rsp_credit && !fifo_pop)
  ) else $error("io_rsp_port: host granted more than 255 credits");

endmodule

`default_nettype wire

//--- src/io_ports_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_ports_top #(
  parameter int REQ_DEPTH = 4,
  parameter int RSP_DEPTH = 4
) (
  input  wire                             sys_clk,
  input  wire                             rst_n,
  input  wire                             req_valid,
  input  wire                             req_wen,
  input  wire                             req_byt,
  input  wire [io_pkg::addr_width-1:0]    req_addr,
  input  wire [io_pkg::data_width-1:0]    req_wdata,
  output logic                            req_credit,
  input  wire                             rsp_credit,
  output logic                            rsp_valid,
  output logic [io_pkg::data_width-1:0]   rsp_rdata,
  output logic [5:0]                      led,
  output logic                            lcd_e,
  output logic                            lcd_rw,
  output logic                            lcd_rs,
  output logic [3:0]                      lcd_db,
  output logic [7:0]                      gpio
);

  io_pkg::req_t                   req_in;
  io_pkg::req_t                   req_head;
  logic                           req_not_empty;
  logic                           req_pop;
  logic [$clog2(RSP_DEPTH+1)-1:0] rsp_free;
  logic                           op_valid;
  logic                           op_wen;
  logic                           op_byt;
  io_pkg::sel_t                   op_sel;
  logic [io_pkg::data_width-1:0]  op_wdata;
  logic                           rd_push;
  logic [io_pkg::data_width-1:0]  rd_data;

  assign req_in = '{wen: req_wen, byt: req_byt, addr: req_addr, wdata: req_wdata};

  // one credit back per entry leaving the queue
  assign req_credit = req_pop;

  io_fifo #(
    .payload_t (io_pkg::req_t),
    .DEPTH     (REQ_DEPTH)
  ) u_req_fifo (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req_in),
    .pop       (req_pop),
    .pop_data  (req_head),
    .not_empty (req_not_empty),
    .free      ()
  );

  io_decode #(
    .RSP_DEPTH (RSP_DEPTH)
  ) u_decode (
    .sys_clk (sys_clk), .rst_n (rst_n),
    .req_not_empty (req_not_empty), .req_data (req_head), .req_pop (req_pop),
    .rsp_free (rsp_free),
    .op_valid (op_valid), .op_wen (op_wen), .op_byt (op_byt),
    .op_sel (op_sel), .op_wdata (op_wdata)
  );

  io_regs u_regs (
    .sys_clk (sys_clk), .rst_n (rst_n),
    .op_valid (op_valid), .op_wen (op_wen), .op_byt (op_byt),
    .op_sel (op_sel), .op_wdata (op_wdata),
    .rd_push (rd_push), .rd_data (rd_data),
    .led (led), .lcd_e (lcd_e), .lcd_rw (lcd_rw), .lcd_rs (lcd_rs),
    .lcd_db (lcd_db), .gpio (gpio)
  );

  io_rsp_port #(
    .DEPTH (RSP_DEPTH)
  ) u_rsp_port (
    .sys_clk (sys_clk), .rst_n (rst_n),
    .rd_push (rd_push), .rd_data (rd_data), .rsp_free (rsp_free),
    .rsp_credit (rsp_credit), .rsp_valid (rsp_valid), .rsp_rdata (rsp_rdata)
  );

endmodule

`default_nettype wire

//--- dv/io_ports_model.svh
`ifndef IO_PORTS_MODEL_SVH
`define IO_PORTS_MODEL_SVH

// shadow copies of the three output registers
logic [7:0] m_led;
logic [7:0] m_lcd;
logic [7:0] m_gpio;

io_pkg::rsp_t exp_q[$];  // read data still owed by the DUT, oldest first

function void model_reset();
  m_led  = 8'h00;
  m_lcd  = 8'h00;
  m_gpio = 8'h00;
  exp_q.delete();
endfunction

function automatic io_pkg::rsp_t model_read(input logic [9:0] addr);
  io_pkg::rsp_t r;
  r.rdata = 16'h0000;  // unmapped reads
  if (addr == 10'h080 || addr == 10'h081)
    r.rdata = {m_lcd, m_led};
  else if (addr == 10'h082 || addr == 10'h083)
    r.rdata = {8'h00, m_gpio};
  return r;
endfunction

// applied when the host issues the request
function void model_apply(input logic wen, input logic byt, input logic [9:0] addr,
                          input logic [15:0] wdata);
  if (!wen) begin
    exp_q.push_back(model_read(addr));
  end else begin
    case (addr)
      10'h080: begin
        if (byt) begin
          m_led = wdata[7:0];
        end else begin
          m_lcd = wdata[15:8];
          m_led = wdata[7:0];
        end
      end
      10'h081: m_lcd  = wdata[15:8];  // high byte lane
      10'h082: m_gpio = wdata[7:0];
      default: ;
    endcase
  end
endfunction

// same order as the packed pin vector in the testbench
function logic [20:0] model_pins();
  return {m_led[5:0], m_lcd[0], m_lcd[1], m_lcd[2], m_lcd[7:4], m_gpio};
endfunction

`endif

//--- dv/io_ports_tb.sv
`timescale 1ns/1ps
`default_nettype none

module io_ports_tb;

  localparam int REQ_DEPTH   = 4;
  localparam int RSP_DEPTH   = 4;
  localparam int n_writes    = 80;   // write-only batches with pin checks
  localparam int n_mixed     = 200;
  localparam int n_stalled   = 160;
  localparam int num_reqs    = n_writes + n_mixed + n_stalled;
  localparam int cycle_limit = 20 * num_reqs + 1000;
  localparam int drain_limit = 200;

  logic        sys_clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_wen;
  logic        req_byt;
  logic [9:0]  req_addr;
  logic [15:0] req_wdata;
  logic        req_credit;
  logic        rsp_credit;
  logic        rsp_valid;
  logic [15:0] rsp_rdata;
  logic [5:0]  led;
  logic        lcd_e;
  logic        lcd_rw;
  logic        lcd_rs;
  logic [3:0]  lcd_db;
  logic [7:0]  gpio;

  int cycle_cnt    = 0;
  int errors       = 0;
  int checks       = 0;
  int req_cred     = REQ_DEPTH;
  int reqs_sent    = 0;
  int reads_sent   = 0;
  int credits_back = 0;
  int granted      = 0;  // response credits handed to the DUT
  int rsp_seen     = 0;
  int stall_left   = 0;
  bit stall_mode   = 1'b0;
  bit hold_rsp     = 1'b0;

  `include "io_ports_model.svh"

  io_ports_top #(
    .REQ_DEPTH (REQ_DEPTH),
    .RSP_DEPTH (RSP_DEPTH)
  ) dut0 (
    .sys_clk (sys_clk), .rst_n (rst_n),
    .req_valid (req_valid), .req_wen (req_wen), .req_byt (req_byt),
    .req_addr (req_addr), .req_wdata (req_wdata), .req_credit (req_credit),
    .rsp_credit (rsp_credit), .rsp_valid (rsp_valid), .rsp_rdata (rsp_rdata),
    .led (led), .lcd_e (lcd_e), .lcd_rw (lcd_rw), .lcd_rs (lcd_rs),
    .lcd_db (lcd_db), .gpio (gpio)
  );

  always #50 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      errors = errors + 1;
      report_and_finish();
    end
  end

  // ************************************************************************
  // compare tasks
  // ************************************************************************

  task automatic check_rsp(input io_pkg::rsp_t got, input io_pkg::rsp_t exp, input int idx);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED @%0t: response %0d data %h, expected %h",
               $time, idx, got.rdata, exp.rdata);
    end
  endtask

  task automatic check_pins(input logic [20:0] exp);
    logic [20:0] got;
    got = {led, lcd_e, lcd_rw, lcd_rs, lcd_db, gpio};
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED @%0t: pins led/e/rw/rs/db/gpio %h, expected %h",
               $time, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task report_and_finish();
    $display("checks %0d, errors %0d, requests %0d, reads %0d, responses %0d",
             checks, errors, reqs_sent, reads_sent, rsp_seen);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  // ************************************************************************
  // host side, one call per falling edge
  // ************************************************************************

  task step_cycle();
    io_pkg::rsp_t got;
    @(negedge sys_clk);
    if (req_credit) begin
      credits_back++;
      req_cred++;
      if (credits_back > reqs_sent) begin
        errors++;
        $display("req_credit returned more credits than requests were sent at %0t", $time);
      end
    end
    if (rsp_valid) begin
      if (granted == rsp_seen) begin
        errors++;
        $display("rsp_valid seen without a granted response credit at %0t", $time);
      end
      got.rdata = rsp_rdata;
      if (exp_q.size() == 0) begin
        errors++;
        $display("response arrived with no read outstanding at %0t", $time);
      end else begin
        check_rsp(got, exp_q.pop_front(), rsp_seen);
      end
      rsp_seen++;
    end
    if (stall_mode) begin  // alternate long holds and short releases
      if (stall_left == 0) begin
        hold_rsp   = !hold_rsp;
        stall_left = hold_rsp ? 30 + $urandom_range(0, 30) : 5 + $urandom_range(0, 15);
      end else begin
        stall_left--;
      end
    end
    rsp_credit = 1'b0;
    if (!hold_rsp && (granted - rsp_seen) < 6 && $urandom_range(0, 3) != 0) begin
      rsp_credit = 1'b1;
      granted++;
    end
    req_valid = 1'b0;
  endtask

  task issue_random_req(input int rd_pct);
    int r;
    r         = $urandom_range(0, 7);
    req_wen   = ($urandom_range(0, 99) >= rd_pct);
    req_byt   = $urandom_range(0, 1) != 0;
    req_wdata = 16'($urandom());
    if (r < 6)
      req_addr = 10'h080 + 10'(r % 4);
    else
      req_addr = 10'($urandom());  // mostly out of map
    req_valid = 1'b1;
    req_cred--;
    reqs_sent++;
    if (!req_wen)
      reads_sent++;
    model_apply(req_wen, req_byt, req_addr, req_wdata);
  endtask

  // all credits home, then room for decode and the register stage
  task wait_drain();
    int waited;
    waited = 0;
    while ((req_cred != REQ_DEPTH || exp_q.size() != 0) && waited < drain_limit) begin
      step_cycle();
      waited++;
    end
    repeat (3) step_cycle();
  endtask

  task run_phase(input int n, input int rd_pct, input bit stalls, input bit pin_batches);
    int done;
    done       = 0;
    stall_mode = stalls;
    while (done < n) begin
      step_cycle();
      if (req_cred > 0 && $urandom_range(0, 99) < 75) begin
        issue_random_req(rd_pct);
        done++;
        if (pin_batches && done % 8 == 0) begin
          wait_drain();
          check_pins(model_pins());
        end
      end
    end
    stall_mode = 1'b0;
    hold_rsp   = 1'b0;
  endtask

  initial begin
    sys_clk    = 1'b0;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_wen    = 1'b0;
    req_byt    = 1'b0;
    req_addr   = 10'h000;
    req_wdata  = 16'h0000;
    rsp_credit = 1'b0;
    void'($urandom(32'hb378));
    model_reset();
    repeat (8) @(posedge sys_clk);
    @(negedge sys_clk);
    rst_n = 1'b1;

    repeat (6) step_cycle();  // idle, nothing may come back
    check_pins(model_pins());

    run_phase(n_writes, 0, 1'b0, 1'b1);
    run_phase(n_mixed, 40, 1'b0, 1'b0);
    run_phase(n_stalled, 60, 1'b1, 1'b0);

    wait_drain();
    check_pins(model_pins());
    check_count(rsp_seen, reads_sent, "responses vs reads");
    check_count(req_cred, REQ_DEPTH, "host request credits");
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- io_ports.f
+incdir+dv
src/io_pkg.sv
src/io_fifo.sv
src/io_decode.sv
src/io_regs.sv
src/io_rsp_port.sv
src/io_ports_top.sv
dv/io_ports_tb.sv

//--- Makefile
# Verilator flow for io_ports; every variable can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= io_ports_tb
RTL_TOP    ?= io_ports_top
FLIST      ?= io_ports.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --assert --timing
LINT_FLAGS ?= -Wall
PASS_MSG   ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status comes from the search for the pass message
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
